// File: run.sh
#!/bin/sh
# build and run the AXI4 write core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_axi4_write_core \
    -Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}

cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/axi4_write_stim.txt
// columns: start address, beats - 1, max burst length - 1, first data word (hex)
// one command per row, beat i carries first data word + i
00001000 00f 0f 10000000
00001ff0 009 0f 20000000
00002000 03f 0f 30000000
00003ff8 000 07 40000000
00004f00 0ff ff 50000000
00005ffc 011 03 60000000
00007002 007 02 70000000
00008e00 3ff ff 80000000
00000ffc 002 3f 90000000
0000a000 0ff ff a0000000

// File: tb/axi_slave_model.sv
// ----------------------------------------------------------
// AXI write slave responder with random stalls, traffic counts
// ----------------------------------------------------------

`timescale 1ns/1ps

module axi_slave_model #(
    parameter logic [31:0] SEED = 32'h9c4b
) (
    input  logic i_aclk,
    input  logic i_rst,
    input  logic i_awvalid,
    output logic o_awready,
    input  logic i_wvalid,
    input  logic i_wlast,
    output logic o_wready,
    output logic o_bvalid,
    input  logic i_bready,
    output int   o_aw_count,
    output int   o_w_count,
    output int   o_b_count
);

    logic [31:0] lfsr      = SEED;
    logic        awready_q = 1'b0;
    logic        wready_q  = 1'b0;
    logic        bvalid_q  = 1'b0;
    // responses owed but not yet presented on B
    int          owed      = 0;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign o_awready = awready_q;
    assign o_wready  = wready_q;
    assign o_bvalid  = bvalid_q;

    always @(posedge i_aclk) begin
        logic [31:0] s;
        logic [2:0]  bits;
        s       = lfsr_next(lfsr);
        bits[0] = s[0];
        s       = lfsr_next(s);
        bits[1] = s[0];
        s       = lfsr_next(s);
        bits[2] = s[0];
        lfsr   <= s;
        if (i_rst) begin
            awready_q  <= 1'b0;
            wready_q   <= 1'b0;
            bvalid_q   <= 1'b0;
            owed        = 0;
            o_aw_count <= 0;
            o_w_count  <= 0;
            o_b_count  <= 0;
        end else begin
            if (i_awvalid && awready_q)
                o_aw_count <= o_aw_count + 1;
            if (i_wvalid && wready_q)
                o_w_count <= o_w_count + 1;
            if (bvalid_q && i_bready)
                o_b_count <= o_b_count + 1;
            awready_q <= bits[0];
            wready_q  <= bits[1];
            // a raised bvalid holds until taken
            if (bvalid_q && !i_bready) begin
                bvalid_q <= 1'b1;
            end else if (owed > 0 && bits[2]) begin
                bvalid_q <= 1'b1;
                owed      = owed - 1;
            end else begin
                bvalid_q <= 1'b0;
            end
            if (i_wvalid && wready_q && i_wlast)
                owed = owed + 1;
        end
    end

endmodule

// File: tb/tb_axi4_write_core.sv
// ----------------------------------------------------------
// testbench for the AXI4 write core, file driven with model
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "axi4_write_params.svh"

module tb_axi4_write_core
    import axi_bus_pkg::*, write_cmd_pkg::*;
();

    localparam int    NUM_ROWS   = 10;
    localparam int    CLK_HALF   = 20;
    localparam int    PAGE_BYTES = 1 << `ALIGN_BITS;
    localparam string STIM_FILE  = "tb/axi4_write_stim.txt";

    logic                   aclk;
    logic                   rst;
    user_cmd_t              cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [`AXI_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    axi_aw_t                m_aw;
    logic                   m_awvalid;
    logic                   m_awready;
    axi_w_t                 m_w;
    logic                   m_wvalid;
    logic                   m_wready;
    logic                   m_bvalid;
    logic                   m_bready;
    logic                   done_valid;
    logic                   done_ready;
    int                     slv_aw_count;
    int                     slv_w_count;
    int                     slv_b_count;

    logic [31:0] stim_mem [NUM_ROWS*4];
    logic [31:0] exp_addr [$];
    int          exp_beats [$];
    int          exp_max [$];
    logic [31:0] exp_data [$];
    int          cum_bursts [NUM_ROWS];
    int          total_beats = 0;
    bit          stim_ready  = 1'b0;

    // monitor state
    int aw_count     = 0;
    int issued_beats = 0;
    int in_count     = 0;
    int w_count      = 0;
    int w_burst      = 0;
    int w_beat       = 0;
    int done_count   = 0;
    int err_aw       = 0;
    int err_w        = 0;
    int err_done     = 0;
    int err_end      = 0;

    axi4_write_core u_axi4_write_core (
        .i_aclk       (aclk),
        .i_rst        (rst),
        .i_cmd        (cmd),
        .i_cmd_valid  (cmd_valid),
        .o_cmd_ready  (cmd_ready),
        .i_wdata      (wdata),
        .i_wvalid     (wvalid),
        .o_wready     (wready),
        .o_m_aw       (m_aw),
        .o_m_awvalid  (m_awvalid),
        .i_m_awready  (m_awready),
        .o_m_w        (m_w),
        .o_m_wvalid   (m_wvalid),
        .i_m_wready   (m_wready),
        .i_m_bvalid   (m_bvalid),
        .o_m_bready   (m_bready),
        .o_done_valid (done_valid),
        .i_done_ready (done_ready)
    );

    axi_slave_model u_axi_slave_model (
        .i_aclk     (aclk),
        .i_rst      (rst),
        .i_awvalid  (m_awvalid),
        .o_awready  (m_awready),
        .i_wvalid   (m_wvalid),
        .i_wlast    (m_w.last),
        .o_wready   (m_wready),
        .o_bvalid   (m_bvalid),
        .i_bready   (m_bready),
        .o_aw_count (slv_aw_count),
        .o_w_count  (slv_w_count),
        .o_b_count  (slv_b_count)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    // ------------------------------------------------------
    // reference model, bursts and data from the stimulus rows
    // ------------------------------------------------------
    task automatic build_expected();
        logic [31:0] addr;
        int          remain;
        int          max_beats;
        int          room;
        int          n;
        int          bursts;
        bursts = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            addr      = stim_mem[4*r] & ~32'h3;
            remain    = int'(stim_mem[4*r+1][`CMD_LEN_W-1:0]) + 1;
            max_beats = int'(stim_mem[4*r+2][`AXI_LEN_W-1:0]) + 1;
            total_beats += remain;
            for (int i = 0; i < remain; i++)
                exp_data.push_back(stim_mem[4*r+3] + 32'(i));
            while (remain > 0) begin
                room = (PAGE_BYTES - int'(addr[`ALIGN_BITS-1:0])) / 4;
                n    = remain;
                if (n > max_beats)
                    n = max_beats;
                if (n > room)
                    n = room;
                exp_addr.push_back(addr);
                exp_beats.push_back(n);
                exp_max.push_back(max_beats);
                addr   = addr + 32'(n * 4);
                remain = remain - n;
                bursts++;
            end
            cum_bursts[r] = bursts;
        end
    endtask

    // ------------------------------------------------------
    // drivers
    // ------------------------------------------------------
    task automatic send_cmd(input int r);
        cmd.addr       <= stim_mem[4*r];
        cmd.beats_m1   <= stim_mem[4*r+1][`CMD_LEN_W-1:0];
        cmd.max_len_m1 <= stim_mem[4*r+2][`AXI_LEN_W-1:0];
        cmd_valid      <= 1'b1;
        do @(posedge aclk); while (!cmd_ready);
    endtask

    task automatic stream_cmds();
        for (int r = 0; r < NUM_ROWS; r++)
            send_cmd(r);
        cmd_valid <= 1'b0;
    endtask

    task automatic send_word(input logic [31:0] word);
        wdata  <= word;
        wvalid <= 1'b1;
        do @(posedge aclk); while (!wready);
    endtask

    // gaps and one long pause keep bursts waiting for data
    task automatic stream_data();
        int k;
        k = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i <= int'(stim_mem[4*r+1][`CMD_LEN_W-1:0]); i++) begin
                send_word(stim_mem[4*r+3] + 32'(i));
                k++;
                if (k == 400) begin
                    wvalid <= 1'b0;
                    repeat (200) @(posedge aclk);
                end else if (k % 4 == 0) begin
                    wvalid <= 1'b0;
                    @(posedge aclk);
                end
            end
        end
        wvalid <= 1'b0;
    endtask

    task automatic hold_done_ready();
        done_ready <= 1'b1;
        repeat (600) @(posedge aclk);
        done_ready <= 1'b0;
        repeat (150) @(posedge aclk);
        done_ready <= 1'b1;
    endtask

    // ------------------------------------------------------
    // monitors
    // ------------------------------------------------------
    task automatic compare_aw();
        logic [31:0] last_byte;
        int          beats;
        beats        = int'(m_aw.len) + 1;
        issued_beats = issued_beats + beats;
        last_byte    = m_aw.addr + 32'(beats * 4) - 32'd1;
        assert (aw_count < exp_addr.size()) else begin
            $display("more AW bursts were issued than the commands need");
            err_aw++;
        end
        if (aw_count < exp_addr.size()) begin
            assert (m_aw.addr == exp_addr[aw_count] && beats == exp_beats[aw_count]) else begin
                $display("Fail %0t: AW %0d got addr %h beats %0d, expected %h beats %0d",
                         $time, aw_count, m_aw.addr, beats,
                         exp_addr[aw_count], exp_beats[aw_count]);
                err_aw++;
            end
            assert (beats <= exp_max[aw_count]) else begin
                $display("Fail %0t: AW %0d has %0d beats, over max %0d",
                         $time, aw_count, beats, exp_max[aw_count]);
                err_aw++;
            end
        end
        assert (last_byte[31:`ALIGN_BITS] == m_aw.addr[31:`ALIGN_BITS]) else begin
            $display("Fail %0t: AW at %h crosses a 4 KB boundary", $time, m_aw.addr);
            err_aw++;
        end
        assert (in_count >= issued_beats) else begin
            $display("Fail %0t: AW issued with %0d beats buffered, %0d claimed",
                     $time, in_count, issued_beats);
            err_aw++;
        end
        aw_count++;
    endtask

    task automatic verify_w_beat();
        logic exp_last;
        assert (w_count < total_beats && w_burst < exp_beats.size()) else begin
            $display("more W beats arrived than the commands carry");
            err_w++;
        end
        if (w_count < total_beats && w_burst < exp_beats.size()) begin
            exp_last = (w_beat == exp_beats[w_burst] - 1);
            assert (m_w.data == exp_data[w_count] && m_w.strb == '1) else begin
                $display("Fail %0t: W beat %0d got %h strb %b, expected %h",
                         $time, w_count, m_w.data, m_w.strb, exp_data[w_count]);
                err_w++;
            end
            assert (m_w.last == exp_last) else begin
                $display("Fail %0t: W beat %0d last %b, expected %b",
                         $time, w_count, m_w.last, exp_last);
                err_w++;
            end
            if (exp_last) begin
                w_burst++;
                w_beat = 0;
            end else begin
                w_beat++;
            end
        end
        w_count++;
    endtask

    task automatic match_completion();
        assert (done_count < NUM_ROWS) else begin
            $display("a completion arrived with no command left to complete");
            err_done++;
        end
        if (done_count < NUM_ROWS) begin
            assert (slv_b_count >= cum_bursts[done_count]) else begin
                $display("Fail %0t: completion %0d after %0d B responses, needs %0d",
                         $time, done_count, slv_b_count, cum_bursts[done_count]);
                err_done++;
            end
        end
        done_count++;
    endtask

    always @(posedge aclk) begin
        if (!rst) begin
            if (m_awvalid && m_awready)
                compare_aw();
            if (m_wvalid && m_wready)
                verify_w_beat();
            if (done_valid && done_ready)
                match_completion();
            if (wvalid && wready)
                in_count++;
        end
    end

    task automatic final_tally();
        assert (aw_count == exp_addr.size() && slv_aw_count == exp_addr.size()
                && w_burst == exp_addr.size()) else begin
            $display("burst count mismatch, %0d AW (%0d at the slave) and %0d W bursts",
                     aw_count, slv_aw_count, w_burst);
            $display("%0d bursts were expected", exp_addr.size());
            err_end++;
        end
        assert (w_count == total_beats && slv_w_count == total_beats) else begin
            $display("beat count mismatch, %0d W beats for %0d expected", w_count, total_beats);
            err_end++;
        end
        assert (slv_b_count == exp_addr.size() && done_count == NUM_ROWS) else begin
            $display("%0d B responses and %0d completions for %0d bursts and %0d commands",
                     slv_b_count, done_count, exp_addr.size(), NUM_ROWS);
            err_end++;
        end
    endtask

    // ------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------
    initial begin
        int fd;
        rst        = 1'b1;
        cmd        = '0;
        cmd_valid  = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        done_ready = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("stimulus file %s could not be opened", STIM_FILE);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            $fclose(fd);
            $readmemh(STIM_FILE, stim_mem);
            build_expected();
            stim_ready = 1'b1;
            repeat (3) @(posedge aclk);
            rst <= 1'b0;
            fork
                stream_cmds();
                stream_data();
                hold_done_ready();
            join
            wait (done_count >= NUM_ROWS && w_count >= total_beats);
            // extra cycles to catch duplicates
            repeat (50) @(posedge aclk);
            final_tally();
            $display("errors: aw %0d, w %0d, done %0d, end %0d",
                     err_aw, err_w, err_done, err_end);
            if (err_aw + err_w + err_done + err_end == 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        wait (stim_ready);
        #(total_beats * 2 * CLK_HALF * 20 + 10000);
        $display("timeout, the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verilog/axi4_write_core.sv
// ----------------------------------------------------------
// AXI4 write master core top level
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "axi4_write_params.svh"

module axi4_write_core
    import axi_bus_pkg::*, write_cmd_pkg::*;
(
    input  logic                   i_aclk,
    input  logic                   i_rst,
    input  user_cmd_t              i_cmd,
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  logic [`AXI_DATA_W-1:0] i_wdata,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output axi_aw_t                o_m_aw,
    output logic                   o_m_awvalid,
    input  logic                   i_m_awready,
    output axi_w_t                 o_m_w,
    output logic                   o_m_wvalid,
    input  logic                   i_m_wready,
    input  logic                   i_m_bvalid,
    output logic                   o_m_bready,
    output logic                   o_done_valid,
    input  logic                   i_done_ready
);

    burst_t                 burst;
    logic                   burst_valid;
    logic                   burst_ready;
    logic                   push;
    logic [`AXI_DATA_W-1:0] fifo_data;
    logic                   fifo_valid;
    logic                   fifo_ready;
    logic                   last_push;
    logic                   last_flag;
    logic                   bq_ready;

    burst_splitter u_burst_splitter (
        .i_aclk        (i_aclk),
        .i_rst         (i_rst),
        .i_cmd         (i_cmd),
        .i_cmd_valid   (i_cmd_valid),
        .o_cmd_ready   (o_cmd_ready),
        .o_burst       (burst),
        .o_burst_valid (burst_valid),
        .i_burst_ready (burst_ready)
    );

    wdata_fifo #(
        .DATA_W    (`AXI_DATA_W),
        .DEPTH_LOG (`WFIFO_DEPTH_LOG)
    ) u_wdata_fifo (
        .i_aclk  (i_aclk),
        .i_rst   (i_rst),
        .i_data  (i_wdata),
        .i_valid (i_wvalid),
        .o_ready (o_wready),
        .o_push  (push),
        .o_data  (fifo_data),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready)
    );

    write_gate u_write_gate (
        .i_aclk        (i_aclk),
        .i_rst         (i_rst),
        .i_burst       (burst),
        .i_burst_valid (burst_valid),
        .o_burst_ready (burst_ready),
        .i_push        (push),
        .i_fifo_data   (fifo_data),
        .i_fifo_valid  (fifo_valid),
        .o_fifo_ready  (fifo_ready),
        .o_m_aw        (o_m_aw),
        .o_m_awvalid   (o_m_awvalid),
        .i_m_awready   (i_m_awready),
        .o_m_w         (o_m_w),
        .o_m_wvalid    (o_m_wvalid),
        .i_m_wready    (i_m_wready),
        .o_last_push   (last_push),
        .o_last_flag   (last_flag),
        .i_bq_ready    (bq_ready)
    );

    bresp_tracker u_bresp_tracker (
        .i_aclk       (i_aclk),
        .i_rst        (i_rst),
        .i_last_push  (last_push),
        .i_last_flag  (last_flag),
        .o_bq_ready   (bq_ready),
        .i_m_bvalid   (i_m_bvalid),
        .o_m_bready   (o_m_bready),
        .o_done_valid (o_done_valid),
        .i_done_ready (i_done_ready)
    );

endmodule

// File: verilog/axi4_write_params.svh
// ----------------------------------------------------------
// widths, depths and burst boundary of the AXI4 write core
// ----------------------------------------------------------

`ifndef AXI4_WRITE_PARAMS_SVH
`define AXI4_WRITE_PARAMS_SVH

// bus side
`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define BYTES_PER_BEAT  (`AXI_DATA_W / 8)
`define AXI_LEN_W       8

// user command beat count, stored as beats - 1
`define CMD_LEN_W       10

// 2^12 = 4 KB boundary
`define ALIGN_BITS      12

// queue depths as log2
`define WFIFO_DEPTH_LOG 9
`define LENQ_DEPTH_LOG  4
`define BQ_DEPTH_LOG    4

`endif

// File: verilog/axi_bus_pkg.sv
// ----------------------------------------------------------
// AXI4 AW and W channel payload structs
// ----------------------------------------------------------

`include "axi4_write_params.svh"

package axi_bus_pkg;

    // one AW beat, fixed sideband fields are left to the slave
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
    } axi_aw_t;

    // one W beat
    typedef struct packed {
        logic [`AXI_DATA_W-1:0]     data;
        logic [`BYTES_PER_BEAT-1:0] strb;
        logic                       last;
    } axi_w_t;

endpackage

// File: verilog/bresp_tracker.sv
// ----------------------------------------------------------
// B response tracker, last-burst flags into completions
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "axi4_write_params.svh"

module bresp_tracker (
    input  logic i_aclk,
    input  logic i_rst,
    input  logic i_last_push,
    input  logic i_last_flag,
    output logic o_bq_ready,
    input  logic i_m_bvalid,
    output logic o_m_bready,
    output logic o_done_valid,
    input  logic i_done_ready
);

    localparam int BQ_DEPTH = 1 << `BQ_DEPTH_LOG;

    logic                   bq_mem [BQ_DEPTH];
    logic [`BQ_DEPTH_LOG:0] bq_wr;
    logic [`BQ_DEPTH_LOG:0] bq_rd;
    logic                   bq_full;
    logic                   bq_empty;
    logic                   b_hs;

    // flags arrive in AW order
    assign bq_empty = (bq_wr == bq_rd);
    assign bq_full  = (bq_wr[`BQ_DEPTH_LOG] != bq_rd[`BQ_DEPTH_LOG])
                   && (bq_wr[`BQ_DEPTH_LOG-1:0] == bq_rd[`BQ_DEPTH_LOG-1:0]);

    assign o_bq_ready = !bq_full;
    // completion slot free or being emptied this cycle
    assign o_m_bready = !bq_empty && (!o_done_valid || i_done_ready);
    assign b_hs       = i_m_bvalid && o_m_bready;

    always_ff @(posedge i_aclk) begin
        if (i_last_push)
            bq_mem[bq_wr[`BQ_DEPTH_LOG-1:0]] <= i_last_flag;
    end

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            bq_wr        <= '0;
            bq_rd        <= '0;
            o_done_valid <= 1'b0;
        end else begin
            if (i_last_push)
                bq_wr <= bq_wr + 1'b1;
            if (b_hs)
                bq_rd <= bq_rd + 1'b1;
            if (b_hs && bq_mem[bq_rd[`BQ_DEPTH_LOG-1:0]])
                o_done_valid <= 1'b1;
            else if (i_done_ready)
                o_done_valid <= 1'b0;
        end
    end

    // every response belongs to an issued burst
    a_b_has_flag: assert property (@(posedge i_aclk) disable iff (i_rst)
        i_m_bvalid |-> !bq_empty)
        else $error("B response with no burst outstanding");

endmodule

// File: verilog/burst_splitter.sv
// ----------------------------------------------------------
// burst splitter, user commands into 4 KB safe INCR bursts
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "axi4_write_params.svh"

module burst_splitter
    import write_cmd_pkg::*;
(
    input  logic      i_aclk,
    input  logic      i_rst,
    input  user_cmd_t i_cmd,
    input  logic      i_cmd_valid,
    output logic      o_cmd_ready,
    output burst_t    o_burst,
    output logic      o_burst_valid,
    input  logic      i_burst_ready
);

    localparam int ADDR_W     = `AXI_ADDR_W;
    localparam int BEAT_SHIFT = $clog2(`BYTES_PER_BEAT);
    localparam int WORD_BITS  = `ALIGN_BITS - BEAT_SHIFT;
    localparam int CNT_W      = ((`CMD_LEN_W > WORD_BITS) ? `CMD_LEN_W : WORD_BITS) + 1;

    split_state_e           state;
    logic [ADDR_W-1:0]      cur_addr;
    logic [CNT_W-1:0]       remain;
    logic [`AXI_LEN_W-1:0]  max_len_m1;
    logic [CNT_W-1:0]       max_beats;
    logic [CNT_W-1:0]       bound_beats;
    logic [CNT_W-1:0]       beats;
    logic [CNT_W-1:0]       beats_m1;
    logic [ADDR_W-1:0]      burst_end;
    logic                   cmd_hs;
    logic                   burst_hs;

    assign cmd_hs   = i_cmd_valid && o_cmd_ready;
    assign burst_hs = o_burst_valid && i_burst_ready;

    // ------------------------------------------------------
    // burst length, min of remaining, max and boundary
    // ------------------------------------------------------
    always_comb begin
        max_beats   = CNT_W'(max_len_m1) + CNT_W'(1);
        bound_beats = CNT_W'(1 << WORD_BITS) - CNT_W'(cur_addr[`ALIGN_BITS-1:BEAT_SHIFT]);
        beats       = remain;
        if (max_beats < beats)
            beats = max_beats;
        if (bound_beats < beats)
            beats = bound_beats;
        beats_m1    = beats - CNT_W'(1);
    end

    assign o_cmd_ready    = (state == S_IDLE);
    assign o_burst_valid  = (state == S_SPLIT);
    assign o_burst.addr   = cur_addr;
    assign o_burst.len_m1 = beats_m1[`AXI_LEN_W-1:0];
    assign o_burst.last   = (beats == remain);

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            state  <= S_IDLE;
            remain <= '0;
        end else if (cmd_hs) begin
            state  <= S_SPLIT;
            remain <= CNT_W'(i_cmd.beats_m1) + CNT_W'(1);
        end else if (burst_hs) begin
            remain <= remain - beats;
            if (beats == remain)
                state <= S_IDLE;
        end
    end

    // address and max length of the command in progress
    always_ff @(posedge i_aclk) begin
        if (cmd_hs) begin
            cur_addr   <= i_cmd.addr & ~ADDR_W'(`BYTES_PER_BEAT - 1);
            max_len_m1 <= i_cmd.max_len_m1;
        end else if (burst_hs) begin
            cur_addr <= cur_addr + (ADDR_W'(beats) << BEAT_SHIFT);
        end
    end

    // ------------------------------------------------------
    // checks
    // ------------------------------------------------------
    assign burst_end = cur_addr + (ADDR_W'(beats_m1) << BEAT_SHIFT);

    // first and last beat share one 4 KB page
    a_no_cross: assert property (@(posedge i_aclk) disable iff (i_rst)
        burst_hs |-> (burst_end[ADDR_W-1:`ALIGN_BITS] == cur_addr[ADDR_W-1:`ALIGN_BITS]))
        else $error("burst at %h crosses the boundary", cur_addr);

endmodule

// File: verilog/wdata_fifo.sv
// ----------------------------------------------------------
// first-word-fall-through data FIFO with push report
// ----------------------------------------------------------

`timescale 1ns/1ps

module wdata_fifo #(
    parameter int DATA_W    = 32,
    parameter int DEPTH_LOG = 9
) (
    input  logic              i_aclk,
    input  logic              i_rst,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_valid,
    output logic              o_ready,
    output logic              o_push,
    output logic [DATA_W-1:0] o_data,
    output logic              o_valid,
    input  logic              i_ready
);

    logic [DATA_W-1:0]  mem [2**DEPTH_LOG];
    logic [DEPTH_LOG:0] wr_ptr;
    logic [DEPTH_LOG:0] rd_ptr;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG] != rd_ptr[DEPTH_LOG])
                && (wr_ptr[DEPTH_LOG-1:0] == rd_ptr[DEPTH_LOG-1:0]);

    assign o_ready = !full;
    assign o_valid = !empty;
    assign o_data  = mem[rd_ptr[DEPTH_LOG-1:0]];
    assign push    = i_valid && !full;
    assign pop     = i_ready && !empty;

    always_ff @(posedge i_aclk) begin
        if (push)
            mem[wr_ptr[DEPTH_LOG-1:0]] <= i_data;
    end

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_push <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            o_push <= push;
        end
    end

    // occupancy never exceeds the depth
    a_no_overflow: assert property (@(posedge i_aclk) disable iff (i_rst)
        (wr_ptr - rd_ptr) <= (DEPTH_LOG+1)'(2**DEPTH_LOG))
        else $error("data FIFO accepted a beat while full");

endmodule

// File: verilog/write_cmd_pkg.sv
// ----------------------------------------------------------
// user command and burst structs, FSM state enums
// ----------------------------------------------------------

`include "axi4_write_params.svh"

package write_cmd_pkg;

    // user write command, counts are minus one
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`CMD_LEN_W-1:0]  beats_m1;
        logic [`AXI_LEN_W-1:0]  max_len_m1;
    } user_cmd_t;

    // boundary-safe burst from the splitter
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len_m1;
        logic                   last;
    } burst_t;

    typedef enum logic {
        S_IDLE,
        S_SPLIT
    } split_state_e;

    typedef enum logic {
        A_WAIT,
        A_ISSUE
    } issue_state_e;

endpackage

// File: verilog/write_gate.sv
// ----------------------------------------------------------
// write gate, capacity checked AW issue and W beat gating
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "axi4_write_params.svh"

module write_gate
    import axi_bus_pkg::*, write_cmd_pkg::*;
(
    input  logic                   i_aclk,
    input  logic                   i_rst,
    input  burst_t                 i_burst,
    input  logic                   i_burst_valid,
    output logic                   o_burst_ready,
    input  logic                   i_push,
    input  logic [`AXI_DATA_W-1:0] i_fifo_data,
    input  logic                   i_fifo_valid,
    output logic                   o_fifo_ready,
    output axi_aw_t                o_m_aw,
    output logic                   o_m_awvalid,
    input  logic                   i_m_awready,
    output axi_w_t                 o_m_w,
    output logic                   o_m_wvalid,
    input  logic                   i_m_wready,
    output logic                   o_last_push,
    output logic                   o_last_flag,
    input  logic                   i_bq_ready
);

    localparam int CAP_W    = `WFIFO_DEPTH_LOG + 1;
    localparam int LEN_W    = `AXI_LEN_W;
    localparam int LQ_DEPTH = 1 << `LENQ_DEPTH_LOG;

    issue_state_e             state;
    burst_t                   aw_burst;
    logic [CAP_W-1:0]         capacity;
    logic [CAP_W-1:0]         need;
    logic [CAP_W-1:0]         aw_beats;
    logic [LEN_W-1:0]         lenq_mem [LQ_DEPTH];
    logic [`LENQ_DEPTH_LOG:0] lq_wr;
    logic [`LENQ_DEPTH_LOG:0] lq_rd;
    logic                     lq_full;
    logic                     lq_empty;
    logic [LEN_W-1:0]         beat_cnt;
    logic                     burst_hs;
    logic                     aw_hs;
    logic                     w_hs;
    logic                     w_last;

    // ------------------------------------------------------
    // AW side
    // ------------------------------------------------------
    assign need     = CAP_W'(i_burst.len_m1) + CAP_W'(1);
    assign aw_beats = CAP_W'(aw_burst.len_m1) + CAP_W'(1);

    // take a burst only once its beats are all buffered
    assign o_burst_ready = (state == A_WAIT) && (capacity >= need) && !lq_full && i_bq_ready;
    assign burst_hs      = i_burst_valid && o_burst_ready;

    assign o_m_awvalid = (state == A_ISSUE);
    assign o_m_aw.addr = aw_burst.addr;
    assign o_m_aw.len  = aw_burst.len_m1;
    assign aw_hs       = o_m_awvalid && i_m_awready;
    assign o_last_push = aw_hs;
    assign o_last_flag = aw_burst.last;

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            state <= A_WAIT;
        end else begin
            case (state)
                A_WAIT:  if (burst_hs) state <= A_ISSUE;
                A_ISSUE: if (aw_hs) state <= A_WAIT;
                default: state <= A_WAIT;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (burst_hs)
            aw_burst <= i_burst;
    end

    // buffered beats not yet claimed by an issued burst
    always_ff @(posedge i_aclk) begin
        if (i_rst)
            capacity <= '0;
        else
            capacity <= capacity + CAP_W'(i_push) - (aw_hs ? aw_beats : CAP_W'(0));
    end

    // ------------------------------------------------------
    // length queue and W gate
    // ------------------------------------------------------
    assign lq_empty = (lq_wr == lq_rd);
    assign lq_full  = (lq_wr[`LENQ_DEPTH_LOG] != lq_rd[`LENQ_DEPTH_LOG])
                   && (lq_wr[`LENQ_DEPTH_LOG-1:0] == lq_rd[`LENQ_DEPTH_LOG-1:0]);

    assign w_last       = (beat_cnt == lenq_mem[lq_rd[`LENQ_DEPTH_LOG-1:0]]);
    assign o_m_wvalid   = i_fifo_valid && !lq_empty;
    assign o_fifo_ready = i_m_wready && !lq_empty;
    assign w_hs         = o_m_wvalid && i_m_wready;
    assign o_m_w.data   = i_fifo_data;
    assign o_m_w.strb   = '1;
    assign o_m_w.last   = w_last;

    always_ff @(posedge i_aclk) begin
        if (aw_hs)
            lenq_mem[lq_wr[`LENQ_DEPTH_LOG-1:0]] <= aw_burst.len_m1;
    end

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            lq_wr    <= '0;
            lq_rd    <= '0;
            beat_cnt <= '0;
        end else begin
            if (aw_hs)
                lq_wr <= lq_wr + 1'b1;
            if (w_hs && w_last) begin
                lq_rd    <= lq_rd + 1'b1;
                beat_cnt <= '0;
            end else if (w_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // unclaimed beats fit in the FIFO, a wrap below zero lands above it
    a_cap_positive: assert property (@(posedge i_aclk) disable iff (i_rst)
        capacity <= CAP_W'(1 << `WFIFO_DEPTH_LOG))
        else $error("capacity below zero");

endmodule

// File: vlog.f
+incdir+verilog
verilog/axi_bus_pkg.sv
verilog/write_cmd_pkg.sv
verilog/burst_splitter.sv
verilog/wdata_fifo.sv
verilog/write_gate.sv
verilog/bresp_tracker.sv
verilog/axi4_write_core.sv
tb/axi_slave_model.sv
tb/tb_axi4_write_core.sv
